//--- hw/dz_pkg.sv
package dz_pkg;

    // Digit held by the counter and shown on the matrix
    localparam int DIGIT_W = 3;

    // Largest digit the glyph table can draw
    localparam logic [DIGIT_W-1:0] MAX_DIGIT = 3'd5;

    // Host command opcodes
    typedef enum logic [1:0]
    {
        OP_LOAD  = 2'd0,
        OP_START = 2'd1,
        OP_PAUSE = 2'd2,
        OP_CLEAR = 2'd3
    } dz_op_e;

    // Countdown states
    typedef enum logic [1:0]
    {
        ST_IDLE  = 2'd0,
        ST_RUN   = 2'd1,
        ST_PAUSE = 2'd2,
        ST_DONE  = 2'd3
    } dz_state_e;

endpackage

//--- hw/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  dz_pkg::dz_op_e             cmd_op,
    input  logic [dz_pkg::DIGIT_W-1:0] cmd_arg,
    output logic                       load_pulse,
    output logic                       start_pulse,
    output logic                       pause_pulse,
    output logic                       clear_pulse,
    output logic [dz_pkg::DIGIT_W-1:0] load_value,
    output logic [7:0]                 reject_count
);
    import dz_pkg::*;

    logic               accept;
    logic               cap_valid;   // A captured command waits for decode
    dz_op_e             cap_op;
    logic [DIGIT_W-1:0] cap_arg;
    logic               cap_bad;

    assign accept  = cmd_valid && cmd_ready;
    assign cap_bad = (cap_op == OP_LOAD) && (cap_arg > MAX_DIGIT);

    // Room for a command on every cycle once out of reset
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cmd_ready <= 1'b0;
        else
            cmd_ready <= 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cap_valid <= 1'b0;
        else
            cap_valid <= accept;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cap_op  <= cmd_op;
            cap_arg <= cmd_arg;
        end
    end

    // One pulse per good command
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            load_pulse   <= 1'b0;
            start_pulse  <= 1'b0;
            pause_pulse  <= 1'b0;
            clear_pulse  <= 1'b0;
            reject_count <= 8'd0;
        end
        else
        begin
            load_pulse  <= cap_valid && (cap_op == OP_LOAD) && !cap_bad;
            start_pulse <= cap_valid && (cap_op == OP_START);
            pause_pulse <= cap_valid && (cap_op == OP_PAUSE);
            clear_pulse <= cap_valid && (cap_op == OP_CLEAR);
            if (cap_valid && cap_bad && (reject_count != 8'hff))
                reject_count <= reject_count + 8'd1;   // Saturates at 255
        end
    end

    always_ff @(posedge clk)
    begin
        if (cap_valid && (cap_op == OP_LOAD) && !cap_bad)
            load_value <= cap_arg;
    end

endmodule

//--- hw/countdown_exec.sv
`timescale 1ns/1ps

module countdown_exec #(
    parameter int TICKS_PER_STEP = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load_pulse,
    input  logic                       start_pulse,
    input  logic                       pause_pulse,
    input  logic                       clear_pulse,
    input  logic [dz_pkg::DIGIT_W-1:0] load_value,
    output logic [dz_pkg::DIGIT_W-1:0] digit,
    output dz_pkg::dz_state_e          state,
    output logic                       done
);
    import dz_pkg::*;

    localparam int PRE_W = (TICKS_PER_STEP > 1) ? $clog2(TICKS_PER_STEP) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(TICKS_PER_STEP - 1);

    logic [PRE_W-1:0]   pre_cnt;
    logic [PRE_W-1:0]   pre_nxt;
    logic [DIGIT_W-1:0] digit_nxt;
    dz_state_e          state_nxt;

    always_comb
    begin
        state_nxt = state;
        digit_nxt = digit;
        pre_nxt   = pre_cnt;

        if (clear_pulse)
        begin
            state_nxt = ST_IDLE;
            digit_nxt = '0;
            pre_nxt   = '0;
        end
        else if (load_pulse)
        begin
            state_nxt = ST_IDLE;
            digit_nxt = load_value;
            pre_nxt   = '0;
        end
        else if (start_pulse)
        begin
            case (state)
                ST_PAUSE:
                    state_nxt = ST_RUN;   // Resume where the prescaler stopped
                ST_IDLE, ST_DONE:
                begin
                    if (digit != '0)
                    begin
                        state_nxt = ST_RUN;
                        pre_nxt   = '0;
                    end
                end
                default:
                    state_nxt = state;
            endcase
        end
        else if (pause_pulse && (state == ST_RUN))
        begin
            state_nxt = ST_PAUSE;
        end
        else if (state == ST_RUN)
        begin
            if (pre_cnt == PRE_LAST)
            begin
                pre_nxt   = '0;
                digit_nxt = digit - 1'b1;
                if (digit == DIGIT_W'(1))
                    state_nxt = ST_DONE;
            end
            else
            begin
                pre_nxt = pre_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= ST_IDLE;
            digit   <= '0;
            pre_cnt <= '0;
            done    <= 1'b0;
        end
        else
        begin
            state   <= state_nxt;
            digit   <= digit_nxt;
            pre_cnt <= pre_nxt;
            done    <= (state_nxt == ST_DONE);   // Tracks ST_DONE exactly
        end
    end

endmodule

//--- hw/glyph_rom.sv
`timescale 1ns/1ps

module glyph_rom (
    input  logic [dz_pkg::DIGIT_W-1:0] digit,
    input  logic [2:0]                 row_idx,
    output logic [7:0]                 pattern
);
    import dz_pkg::*;

    // Glyphs sit in rows 1 to 7, six columns wide
    always_comb
    begin
        pattern = 8'b0000_0000;
        if ((row_idx != 3'd0) && (digit <= MAX_DIGIT))
        begin
            case (digit)
                3'd5:
                begin
                    case (row_idx)
                        3'd1:       pattern = 8'b0111_1110;
                        3'd2:       pattern = 8'b0110_0000;
                        3'd3:       pattern = 8'b0111_1100;
                        3'd4, 3'd5: pattern = 8'b0000_0110;
                        3'd6:       pattern = 8'b0110_0110;
                        default:    pattern = 8'b0011_1100;
                    endcase
                end
                3'd4:
                begin
                    case (row_idx)
                        3'd1:       pattern = 8'b0000_1100;
                        3'd2:       pattern = 8'b0001_1100;
                        3'd3:       pattern = 8'b0010_1100;
                        3'd4:       pattern = 8'b0100_1100;
                        3'd5:       pattern = 8'b0111_1110;
                        default:    pattern = 8'b0000_1100;   // Stem, rows 6 and 7
                    endcase
                end
                3'd3:
                begin
                    case (row_idx)
                        3'd1:       pattern = 8'b0011_1100;
                        3'd2:       pattern = 8'b0110_0110;
                        3'd3:       pattern = 8'b0000_0110;
                        3'd4:       pattern = 8'b0001_1100;
                        3'd5:       pattern = 8'b0000_0110;
                        3'd6:       pattern = 8'b0110_0110;
                        default:    pattern = 8'b0011_1100;
                    endcase
                end
                3'd2:
                begin
                    case (row_idx)
                        3'd1:       pattern = 8'b0011_1100;
                        3'd2:       pattern = 8'b0110_0110;
                        3'd3:       pattern = 8'b0000_0110;
                        3'd4:       pattern = 8'b0000_1100;
                        3'd5:       pattern = 8'b0011_0000;
                        3'd6:       pattern = 8'b0110_0000;
                        default:    pattern = 8'b0111_1110;
                    endcase
                end
                3'd1:
                begin
                    case (row_idx)
                        3'd2:       pattern = 8'b0011_1000;
                        3'd7:       pattern = 8'b0111_1110;   // Foot
                        default:    pattern = 8'b0001_1000;
                    endcase
                end
                default:
                begin
                    // Digit 0
                    case (row_idx)
                        3'd1, 3'd7: pattern = 8'b0011_1100;
                        3'd3:       pattern = 8'b0110_1110;
                        3'd4:       pattern = 8'b0111_0110;
                        default:    pattern = 8'b0110_0110;
                    endcase
                end
            endcase
        end
    end

endmodule

//--- hw/matrix_scan.sv
`timescale 1ns/1ps

module matrix_scan #(
    parameter int SCAN_DIV = 1000
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [dz_pkg::DIGIT_W-1:0] digit,
    output logic [7:0]                 row,
    output logic [7:0]                 colr,
    output logic [7:0]                 colg
);
    import dz_pkg::*;

    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCAN_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       row_idx;
    logic [7:0]       pattern;
    logic             red_on;
    logic             green_on;

    glyph_rom glyph_i (
        .digit   (digit),
        .row_idx (row_idx),
        .pattern (pattern)
    );

    // Red for 5 and 4, both for 3 and 2, green for 1 and 0
    assign red_on   = (digit >= DIGIT_W'(2));
    assign green_on = (digit <= DIGIT_W'(3));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            row_idx <= 3'd0;
        end
        else if (div_cnt == DIV_LAST)
        begin
            div_cnt <= '0;
            row_idx <= row_idx + 3'd1;   // Wraps 7 -> 0
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= 8'd0;   // No row driven
            colr <= 8'd0;
            colg <= 8'd0;
        end
        else
        begin
            row  <= 8'd1 << row_idx;
            colr <= red_on ? pattern : 8'd0;
            colg <= green_on ? pattern : 8'd0;
        end
    end

endmodule

//--- hw/dz_countdown_top.sv
`timescale 1ns/1ps

module dz_countdown_top #(
    parameter int TICKS_PER_STEP = 25_000_000,
    parameter int SCAN_DIV       = 1000
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  dz_pkg::dz_op_e             cmd_op,
    input  logic [dz_pkg::DIGIT_W-1:0] cmd_arg,
    output logic [7:0]                 row,
    output logic [7:0]                 colr,
    output logic [7:0]                 colg,
    output logic [dz_pkg::DIGIT_W-1:0] digit,
    output dz_pkg::dz_state_e          state,
    output logic                       done,
    output logic [7:0]                 reject_count
);
    import dz_pkg::*;

    logic               load_pulse;
    logic               start_pulse;
    logic               pause_pulse;
    logic               clear_pulse;
    logic [DIGIT_W-1:0] load_value;

    cmd_decode decode_i (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_op       (cmd_op),
        .cmd_arg      (cmd_arg),
        .load_pulse   (load_pulse),
        .start_pulse  (start_pulse),
        .pause_pulse  (pause_pulse),
        .clear_pulse  (clear_pulse),
        .load_value   (load_value),
        .reject_count (reject_count)
    );

    countdown_exec #(
        .TICKS_PER_STEP (TICKS_PER_STEP)
    ) exec_i (
        .clk         (clk),
        .rst         (rst),
        .load_pulse  (load_pulse),
        .start_pulse (start_pulse),
        .pause_pulse (pause_pulse),
        .clear_pulse (clear_pulse),
        .load_value  (load_value),
        .digit       (digit),
        .state       (state),
        .done        (done)
    );

    // Display follows the live digit
    matrix_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) scan_i (
        .clk   (clk),
        .rst   (rst),
        .digit (digit),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

endmodule

//--- bench/tb_dz_countdown.sv
`timescale 1ns/1ps

module tb_dz_countdown;
    import dz_pkg::*;

    localparam int TICKS_PER_STEP = 16;
    localparam int SCAN_DIV       = 1;

    logic               clk;
    logic               rst;
    logic               cmd_valid;
    logic               cmd_ready;
    dz_op_e             cmd_op;
    logic [DIGIT_W-1:0] cmd_arg;
    logic [7:0]         row;
    logic [7:0]         colr;
    logic [7:0]         colg;
    logic [DIGIT_W-1:0] digit;
    dz_state_e          state;
    logic               done;
    logic [7:0]         reject_count;

    logic [7:0]         glyph_ref [0:5][0:7];   // Reference glyphs from the stimulus file
    logic [7:0]         kind_q[$];
    int                 op_q[$];
    int                 arg_q[$];
    int                 wait_q[$];
    int                 digit_q[$];
    int                 state_q[$];
    int                 reject_q[$];

    int                 cycle_count = 0;
    int                 cycle_limit = 200;
    int                 error_count = 0;
    bit                 scan_on = 1'b0;
    logic [7:0]         last_row = 8'd0;
    logic [DIGIT_W-1:0] last_digit = '0;

    dz_countdown_top #(
        .TICKS_PER_STEP (TICKS_PER_STEP),
        .SCAN_DIV       (SCAN_DIV)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_op       (cmd_op),
        .cmd_arg      (cmd_arg),
        .row          (row),
        .colr         (colr),
        .colg         (colg),
        .digit        (digit),
        .state        (state),
        .done         (done),
        .reject_count (reject_count)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic step();
        @(posedge clk);
        #1;   // Drive and sample just after the edge
    endtask

    task automatic report_mismatch(input string name, input int got, input int exp);
        error_count++;
        $display("CHECK FAILED at %0t: %s got 'h%0h expected 'h%0h", $time, name, got, exp);
        $display("** FAIL **");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("Error at %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else report_mismatch(name, got, exp);
    endtask

    task automatic check_outputs(input int exp_digit, input int exp_state, input int exp_rej);
        check_value("digit", digit, exp_digit);
        check_value("state", state, exp_state);
        check_value("done", done, exp_state == int'(ST_DONE));
        check_value("reject_count", reject_count, exp_rej);
    endtask

    function automatic bit one_hot(input logic [7:0] v);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++)
            ones += v[i];
        return ones == 1;
    endfunction

    function automatic int row_index(input logic [7:0] v);
        int idx;
        idx = 0;
        for (int i = 0; i < 8; i++)
            if (v[i])
                idx = i;
        return idx;
    endfunction

    // Red for 5 and 4, yellow for 3 and 2, green for 1 and 0
    function automatic logic [7:0] red_part(input int d, input logic [7:0] glyph);
        case (d)
            5, 4, 3, 2: return glyph;
            default:    return 8'd0;
        endcase
    endfunction

    function automatic logic [7:0] green_part(input int d, input logic [7:0] glyph);
        case (d)
            3, 2, 1, 0: return glyph;
            default:    return 8'd0;
        endcase
    endfunction

    task automatic load_stimulus();
        int               fd;
        int               n;
        int               d;
        int               v;
        int               op;
        int               arg;
        int               wt;
        int               st;
        int               rj;
        logic [63:0]      tag;
        logic [8*160-1:0] rest;
        fd = $fopen("bench/dz_stim.txt", "r");
        if (fd == 0)
            report_error("cannot open bench/dz_stim.txt");
        while ($fscanf(fd, "%s", tag) == 1)
        begin
            if (tag == "#")
                n = $fgets(rest, fd);
            else if (tag == "G")
            begin
                n = $fscanf(fd, "%d", d);
                glyph_ref[d][0] = 8'd0;   // Row 0 stays dark
                for (int r = 1; r < 8; r++)
                begin
                    n = $fscanf(fd, "%h", v);
                    glyph_ref[d][r] = v[7:0];
                end
            end
            else if ((tag == "C") || (tag == "W") || (tag == "M"))
            begin
                op  = 0;
                arg = 0;
                wt  = 0;
                if (tag == "C")
                    n = $fscanf(fd, "%d %d", op, arg);
                if (tag != "M")
                    n = $fscanf(fd, "%d", wt);
                n = $fscanf(fd, "%d %d %d", d, st, rj);
                kind_q.push_back(tag[7:0]);
                op_q.push_back(op);
                arg_q.push_back(arg);
                wait_q.push_back(wt);
                digit_q.push_back(d);
                state_q.push_back(st);
                reject_q.push_back(rj);
                cycle_limit += wt;
            end
            else
                report_error("unknown line type in the stimulus file");
        end
        $fclose(fd);
    endtask

    // Returns the edge on which the command transferred
    task automatic send_command(input int op, input int arg, output int acc_cycle);
        int waited;
        waited    = 0;
        cmd_valid = 1'b1;
        cmd_op    = dz_op_e'(op);
        cmd_arg   = arg[DIGIT_W-1:0];
        while (!cmd_ready)
        begin
            step();
            waited++;
            if (waited > 20)
                report_error("cmd_ready stayed low and the command was never accepted");
        end
        step();
        acc_cycle = cycle_count;
        cmd_valid = 1'b0;
    endtask

    task automatic time_next_step(output int cycles);
        logic [DIGIT_W-1:0] held;
        held   = digit;
        cycles = 0;
        while (digit == held)
        begin
            step();
            cycles++;
            if (cycles > 2 * TICKS_PER_STEP)
                report_error("digit did not step down after resume");
        end
    endtask

    // Display check, skipped for one cycle after a digit change
    always @(negedge clk)
    begin : scan_check
        logic [7:0] glyph;
        if (scan_on)
        begin
            assert (one_hot(row))
            else report_error($sformatf("row 'h%02h is not one-hot", row));
            if (last_row != 8'd0)
                check_value("row", row, {last_row[6:0], last_row[7]});
            if (digit == last_digit)
            begin
                glyph = glyph_ref[digit][row_index(row)];
                check_value("colr", colr, red_part(digit, glyph));
                check_value("colg", colg, green_part(digit, glyph));
            end
            last_row = row;
        end
        last_digit = digit;
    end

    initial
    begin : main_flow
        int acc;
        int gap;
        int prev_state;
        int run_start;
        int used;
        int resume_at;
        int cycles;
        int expected;
        clk        = 1'b0;
        rst        = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = OP_LOAD;
        cmd_arg    = '0;
        gap        = $urandom(6523);   // Seeds the generator
        run_start  = 0;
        used       = 0;
        resume_at  = 0;
        prev_state = ST_IDLE;
        load_stimulus();

        step();
        check_value("cmd_ready", cmd_ready, 0);
        check_value("row", row, 0);
        check_value("colr", colr, 0);
        check_value("colg", colg, 0);
        check_outputs(0, ST_IDLE, 0);
        step();
        rst = 1'b0;
        step();
        check_value("cmd_ready", cmd_ready, 1);
        scan_on = 1'b1;

        for (int i = 0; i < kind_q.size(); i++)
        begin
            if (kind_q[i] == "M")
            begin
                expected = TICKS_PER_STEP - used - (cycle_count - resume_at);
                time_next_step(cycles);
                check_value("cycles to next decrement", cycles, expected);
            end
            else
            begin
                if (kind_q[i] == "C")
                begin
                    gap = $urandom % 4;
                    repeat (gap)
                        step();
                    send_command(op_q[i], arg_q[i], acc);
                    // Command takes effect two edges after transfer
                    if ((op_q[i] == OP_START) && (prev_state != ST_PAUSE))
                        run_start = acc + 2;
                    if ((op_q[i] == OP_PAUSE) && (prev_state == ST_RUN))
                        used = (acc + 2 - run_start - 1) % TICKS_PER_STEP;
                    if ((op_q[i] == OP_START) && (prev_state == ST_PAUSE))
                        resume_at = acc + 2;
                end
                repeat (wait_q[i])
                    step();
            end
            check_outputs(digit_q[i], state_q[i], reject_q[i]);
            prev_state = state_q[i];
        end

        if (error_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- bench/dz_stim.txt
# G digit, then the column patterns of rows 1 to 7 in hex (row 0 is blank)
# C op arg wait digit state reject / W wait digit state reject / M digit state reject
# op 0 LOAD 1 START 2 PAUSE 3 CLEAR, state 0 IDLE 1 RUN 2 PAUSE 3 DONE
G 5 7e 60 7c 06 06 66 3c
G 4 0c 1c 2c 4c 7e 0c 0c
G 3 3c 66 06 1c 06 66 3c
G 2 3c 66 06 0c 30 60 7e
G 1 18 38 18 18 18 18 7e
G 0 3c 66 6e 76 66 66 3c
# Load every digit, then two loads out of range
C 0 0 12 0 0 0
C 0 1 12 1 0 0
C 0 2 12 2 0 0
C 0 3 12 3 0 0
C 0 4 12 4 0 0
C 0 6 4 4 0 1
C 0 7 4 4 0 2
C 0 5 12 5 0 2
# Count down from 5, checked at each step of 16 cycles
C 1 0 2 5 1 2
W 15 5 1 2
W 1 4 1 2
W 16 3 1 2
W 16 2 1 2
W 16 1 1 2
W 15 1 1 2
W 1 0 3 2
# Start with digit 0 has no effect
C 1 0 6 0 3 2
# Pause, hold, resume and time the rest of the step
C 0 3 4 3 0 2
C 1 0 2 3 1 2
W 20 2 1 2
C 2 0 2 2 2 2
W 40 2 2 2
C 2 0 4 2 2 2
C 1 0 2 2 1 2
M 1 1 2
C 3 0 2 0 0 2
# Clear while running, then one more bad load
C 0 5 12 5 0 2
C 1 0 2 5 1 2
C 3 0 2 0 0 2
C 0 6 4 0 0 3

//--- compile.f
hw/dz_pkg.sv
hw/cmd_decode.sv
hw/countdown_exec.sv
hw/glyph_rom.sv
hw/matrix_scan.sv
hw/dz_countdown_top.sv
bench/tb_dz_countdown.sv
